// ==== design/icache_pkg.sv ====
/*
 * Instruction cache shared definitions
 * Fixed geometry, PC field positions and controller states
 */
`default_nettype none

package icache_pkg;

    // ########################################
    // Geometry
    // ########################################

    // Program counter width
    localparam int unsigned PC_WIDTH = 16;
    // One encoded instruction
    localparam int unsigned INST_WIDTH = 32;

    // Word within a line
    localparam int unsigned OFFSET_BITS = 1;
    localparam int unsigned WORDS_PER_LINE = 1 << OFFSET_BITS;
    localparam int unsigned LINE_WIDTH = WORDS_PER_LINE * INST_WIDTH;

    // Line select, direct mapped
    localparam int unsigned INDEX_BITS = 4;
    localparam int unsigned NUM_LINES = 1 << INDEX_BITS;

    // PC = {tag, index, offset}
    localparam int unsigned TAG_BITS = PC_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int unsigned INDEX_LSB = OFFSET_BITS;
    localparam int unsigned TAG_LSB = OFFSET_BITS + INDEX_BITS;

    // Memory side addresses whole lines
    localparam int unsigned LINE_ADDR_BITS = PC_WIDTH - OFFSET_BITS;

    // ########################################
    // Controller states
    // ########################################

    typedef enum logic [1:0] {
        // Waiting for a fetch request
        ST_IDLE     = 2'd0,
        // Tag and data read done, resolve hit or miss
        ST_LOOKUP   = 2'd1,
        // Line request sent, waiting for the response
        ST_WAIT_MEM = 2'd2,
        // Refill done, word offered to the decoder
        ST_WAIT_DEC = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/icache_lookup.sv ====
/*
 * Instruction cache tag side
 * Tag array and valid bits with a one-cycle read and the hit compare
 */
`timescale 1ns/1ps
`default_nettype none

module icache_lookup (
    input  wire                                clk_i,
    input  wire                                reset_i,
    // Read the line of the incoming fetch
    input  wire                                lookup_en_i,
    input  wire [icache_pkg::PC_WIDTH-1:0]     fe_pc_i,
    // Write the line of the held request
    input  wire                                refill_en_i,
    input  wire                                invalidate_i,
    input  wire [icache_pkg::PC_WIDTH-1:0]     req_pc_i,
    output logic                               hit_o
);

    // ########################################
    // Address fields
    // ########################################

    logic [icache_pkg::INDEX_BITS-1:0] rd_index;
    logic [icache_pkg::INDEX_BITS-1:0] wr_index;
    logic [icache_pkg::TAG_BITS-1:0]   req_tag;

    // Read side follows the fetcher
    assign rd_index = fe_pc_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS];
    // Write side and compare use the held request
    assign wr_index = req_pc_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS];
    assign req_tag  = req_pc_i[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS];

    // ########################################
    // Storage
    // ########################################

    // One tag per line
    logic [icache_pkg::TAG_BITS-1:0] tag_mem [icache_pkg::NUM_LINES];
    // One valid bit per line
    logic [icache_pkg::NUM_LINES-1:0] valid_q;

    // Registered read result
    logic [icache_pkg::TAG_BITS-1:0] rd_tag_q;
    logic                            rd_valid_q;

    // Tag write on refill
    always_ff @(posedge clk_i) begin
        if (refill_en_i) begin
            tag_mem[wr_index] <= req_tag;
        end
    end

    // Tag read, held until the next lookup
    always_ff @(posedge clk_i) begin
        if (lookup_en_i) begin
            rd_tag_q <= tag_mem[rd_index];
        end
    end

    // Valid vector
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (invalidate_i) begin
            // Flush drops every line at once
            valid_q <= '0;
        end else if (refill_en_i) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // Valid read alongside the tag
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_valid_q <= 1'b0;
        end else if (lookup_en_i) begin
            rd_valid_q <= valid_q[rd_index];
        end
    end

    // Hit when the line was valid and belongs to the held PC
    assign hit_o = rd_valid_q && (rd_tag_q == req_tag);

    // Controller never refills and flushes in the same cycle
    a_refill_vs_flush: assert property (@(posedge clk_i) disable iff (reset_i)
        !(refill_en_i && invalidate_i))
        else $error("icache_lookup: refill and invalidate together");

endmodule

`default_nettype wire

// ==== design/icache_ctrl.sv ====
/*
 * Instruction cache controller
 * Request capture, hit/miss resolution, line refill and pending flush
 */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                                   clk_i,
    input  wire                                   reset_i,
    input  wire                                   flush_i,
    // Fetcher
    input  wire                                   fe_valid_i,
    input  wire [icache_pkg::PC_WIDTH-1:0]        fe_pc_i,
    output logic                                  ic_ready_o,
    // Tag side result
    input  wire                                   hit_i,
    // Memory
    input  wire                                   mem_ready_i,
    input  wire                                   mem_valid_i,
    output logic                                  mem_req_o,
    output logic [icache_pkg::LINE_ADDR_BITS-1:0] mem_addr_o,
    // Decoder
    input  wire                                   dec_ready_i,
    output logic                                  ic_valid_o,
    // Array controls
    output logic                                  lookup_en_o,
    output logic                                  refill_en_o,
    output logic                                  invalidate_o,
    output logic                                  use_refill_o,
    output logic [icache_pkg::PC_WIDTH-1:0]       req_pc_o
);

    // ########################################
    // State
    // ########################################

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;

    // Flush waits here until a safe point
    logic flush_q;
    logic flush_d;

    // Held request
    logic [icache_pkg::PC_WIDTH-1:0] req_pc_q;
    logic [icache_pkg::PC_WIDTH-1:0] req_pc_d;

    // Idle, or the offered word leaves this cycle
    logic slot_free;

    // ########################################
    // Outputs
    // ########################################

    // Word on offer after a hit or a finished refill
    assign ic_valid_o = (state_q == icache_pkg::ST_WAIT_DEC)
                     || ((state_q == icache_pkg::ST_LOOKUP) && hit_i);
    // Refill buffer only after a miss
    assign use_refill_o = (state_q == icache_pkg::ST_WAIT_DEC);

    // Miss keeps the line request up until memory takes it
    assign mem_req_o  = (state_q == icache_pkg::ST_LOOKUP) && !hit_i;
    assign mem_addr_o = req_pc_q[icache_pkg::PC_WIDTH-1:icache_pkg::OFFSET_BITS];

    // Response writes tag, valid bit and data line
    assign refill_en_o = (state_q == icache_pkg::ST_WAIT_MEM) && mem_valid_i;

    assign slot_free = (state_q == icache_pkg::ST_IDLE) || (ic_valid_o && dec_ready_i);

    // Pending flush wins over a new request
    assign ic_ready_o   = slot_free && !flush_q;
    assign invalidate_o = slot_free && flush_q;
    assign lookup_en_o  = ic_ready_o && fe_valid_i;

    assign req_pc_o = req_pc_q;

    // ########################################
    // Next state
    // ########################################

    always_comb begin
        state_d  = state_q;
        req_pc_d = req_pc_q;
        // Latch any flush pulse
        flush_d  = flush_q || flush_i;

        case (state_q)
            icache_pkg::ST_LOOKUP: begin
                // Hit leaves through the free slot below
                if (!hit_i && mem_ready_i) begin
                    state_d = icache_pkg::ST_WAIT_MEM;
                end
            end
            icache_pkg::ST_WAIT_MEM: begin
                if (mem_valid_i) begin
                    state_d = icache_pkg::ST_WAIT_DEC;
                end
            end
            default: begin
                // Idle and decoder wait move only on a free slot
                state_d = state_q;
            end
        endcase

        // Safe point for a flush or the next request
        if (invalidate_o) begin
            flush_d = 1'b0;
            state_d = icache_pkg::ST_IDLE;
        end else if (lookup_en_o) begin
            req_pc_d = fe_pc_i;
            state_d  = icache_pkg::ST_LOOKUP;
        end else if (slot_free) begin
            state_d = icache_pkg::ST_IDLE;
        end
    end

    // ########################################
    // Registers
    // ########################################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= icache_pkg::ST_IDLE;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            flush_q <= flush_d;
        end
    end

    // Held request PC
    always_ff @(posedge clk_i) begin
        req_pc_q <= req_pc_d;
    end

    // Memory answers only an outstanding line request
    a_resp_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_valid_i |-> (state_q == icache_pkg::ST_WAIT_MEM))
        else $error("icache_ctrl: memory response outside ST_WAIT_MEM");

    // Offer holds under decoder back-pressure
    a_offer_held: assert property (@(posedge clk_i) disable iff (reset_i)
        (ic_valid_o && !dec_ready_i) |=> (ic_valid_o && $stable(req_pc_o)))
        else $error("icache_ctrl: offered word dropped while decoder stalled");

endmodule

`default_nettype wire

// ==== design/icache_data_array.sv ====
/*
 * Instruction cache data side
 * Line array, refill buffer and the word select toward the decoder
 */
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
    input  wire                                clk_i,
    input  wire                                reset_i,
    input  wire                                lookup_en_i,
    input  wire [icache_pkg::PC_WIDTH-1:0]     fe_pc_i,
    input  wire                                refill_en_i,
    input  wire [icache_pkg::PC_WIDTH-1:0]     req_pc_i,
    input  wire [icache_pkg::LINE_WIDTH-1:0]   mem_data_i,
    input  wire                                use_refill_i,
    output logic [icache_pkg::INST_WIDTH-1:0]  ic_inst_o
);

    // Instruction lines
    logic [icache_pkg::LINE_WIDTH-1:0] inst_mem [icache_pkg::NUM_LINES];

    // Registered array read and the line just refilled
    logic [icache_pkg::LINE_WIDTH-1:0] rd_line_q;
    logic [icache_pkg::LINE_WIDTH-1:0] refill_q;

    // Line seen as words
    logic [icache_pkg::WORDS_PER_LINE-1:0][icache_pkg::INST_WIDTH-1:0] sel_line;
    logic [icache_pkg::OFFSET_BITS-1:0] word_sel;

    // Array write from the memory response
    always_ff @(posedge clk_i) begin
        if (refill_en_i) begin
            inst_mem[req_pc_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS]] <= mem_data_i;
        end
    end

    // Array read, one cycle behind the lookup
    always_ff @(posedge clk_i) begin
        if (lookup_en_i) begin
            rd_line_q <= inst_mem[fe_pc_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS]];
        end
    end

    // Refill buffer, zero until the first refill
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            refill_q <= '0;
        end else if (refill_en_i) begin
            refill_q <= mem_data_i;
        end
    end

    // Miss path reads the buffer, hit path the array
    assign sel_line = use_refill_i ? refill_q : rd_line_q;
    assign word_sel = req_pc_i[icache_pkg::OFFSET_BITS-1:0];
    assign ic_inst_o = sel_line[word_sel];

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
/*
 * Direct-mapped instruction cache between fetcher and decoder
 * Ties tag side, controller and data side together
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                                  clk_i,
    input  wire                                  reset_i,
    input  wire                                  flush_i,
    // Fetcher
    input  wire                                  fe_valid_i,
    input  wire [icache_pkg::PC_WIDTH-1:0]       fe_pc_i,
    output wire                                  ic_ready_o,
    // Decoder
    output wire                                  ic_valid_o,
    output wire [icache_pkg::PC_WIDTH-1:0]       ic_pc_o,
    output wire [icache_pkg::INST_WIDTH-1:0]     ic_inst_o,
    input  wire                                  dec_ready_i,
    // Memory
    output wire                                  mem_req_o,
    output wire [icache_pkg::LINE_ADDR_BITS-1:0] mem_addr_o,
    input  wire                                  mem_ready_i,
    input  wire                                  mem_valid_i,
    input  wire [icache_pkg::LINE_WIDTH-1:0]     mem_data_i
);

    // Controller to arrays
    wire                              lookup_en;
    wire                              refill_en;
    wire                              invalidate;
    wire                              use_refill;
    wire [icache_pkg::PC_WIDTH-1:0]   req_pc;
    // Tag side to controller
    wire                              hit;

    // Held PC goes to the decoder with its word
    assign ic_pc_o = req_pc;

    icache_lookup u_lookup (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .lookup_en_i  (lookup_en),
        .fe_pc_i      (fe_pc_i),
        .refill_en_i  (refill_en),
        .invalidate_i (invalidate),
        .req_pc_i     (req_pc),
        .hit_o        (hit)
    );

    icache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .fe_valid_i   (fe_valid_i),
        .fe_pc_i      (fe_pc_i),
        .ic_ready_o   (ic_ready_o),
        .hit_i        (hit),
        .mem_ready_i  (mem_ready_i),
        .mem_valid_i  (mem_valid_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .dec_ready_i  (dec_ready_i),
        .ic_valid_o   (ic_valid_o),
        .lookup_en_o  (lookup_en),
        .refill_en_o  (refill_en),
        .invalidate_o (invalidate),
        .use_refill_o (use_refill),
        .req_pc_o     (req_pc)
    );

    icache_data_array u_data (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .lookup_en_i  (lookup_en),
        .fe_pc_i      (fe_pc_i),
        .refill_en_i  (refill_en),
        .req_pc_i     (req_pc),
        .mem_data_i   (mem_data_i),
        .use_refill_i (use_refill),
        .ic_inst_o    (ic_inst_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
/*
 * Testbench clock and reset source
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset drops on a falling edge like every other input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/icache_mem_model.sv ====
/*
 * Line memory responder for the cache testbench
 * Random ready stall and response delay, data derived from the PC
 */
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model (
    input  wire                                   clk_i,
    input  wire                                   reset_i,
    input  wire                                   mem_req_i,
    input  wire [icache_pkg::LINE_ADDR_BITS-1:0]  mem_addr_i,
    output logic                                  mem_ready_o,
    output logic                                  mem_valid_o,
    output logic [icache_pkg::LINE_WIDTH-1:0]     mem_data_o
);

    // Delay limits in cycles
    localparam int MAX_STALL = 3;
    localparam int MAX_LATENCY = 5;

    // Responder phases
    localparam int PH_IDLE = 0;
    localparam int PH_STALL = 1;
    localparam int PH_OFFER = 2;
    localparam int PH_RESPOND = 3;

    integer seed;
    int     phase;
    int     count;
    logic [icache_pkg::LINE_ADDR_BITS-1:0] line_addr;

    // Each word is {pc, ~pc} for the PC it sits at
    function automatic logic [icache_pkg::LINE_WIDTH-1:0] line_for_addr(
        input logic [icache_pkg::LINE_ADDR_BITS-1:0] addr);
        logic [icache_pkg::PC_WIDTH-1:0]   pc;
        logic [icache_pkg::LINE_WIDTH-1:0] line;
        int                                w;
        for (w = 0; w < icache_pkg::WORDS_PER_LINE; w++) begin
            pc = {addr, w[icache_pkg::OFFSET_BITS-1:0]};
            line[w*icache_pkg::INST_WIDTH +: icache_pkg::INST_WIDTH] = {pc, ~pc};
        end
        return line;
    endfunction

    initial begin
        seed = 93;
        phase = PH_IDLE;
        count = 0;
        mem_ready_o = 1'b0;
        mem_valid_o = 1'b0;
        mem_data_o = '0;
    end

    always @(negedge clk_i) begin
        // Response is a single-cycle pulse
        mem_valid_o <= 1'b0;
        if (reset_i) begin
            phase = PH_IDLE;
            mem_ready_o <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (mem_req_i) begin
                        line_addr = mem_addr_i;
                        count = $unsigned($random(seed)) % (MAX_STALL + 1);
                        if (count == 0) begin
                            mem_ready_o <= 1'b1;
                            phase = PH_OFFER;
                        end else begin
                            phase = PH_STALL;
                        end
                    end
                end
                PH_STALL: begin
                    count = count - 1;
                    if (count == 0) begin
                        mem_ready_o <= 1'b1;
                        phase = PH_OFFER;
                    end
                end
                PH_OFFER: begin
                    // Request held with ready high, so it went at the last edge
                    mem_ready_o <= 1'b0;
                    count = $unsigned($random(seed)) % MAX_LATENCY;
                    phase = PH_RESPOND;
                end
                default: begin
                    if (count == 0) begin
                        mem_valid_o <= 1'b1;
                        mem_data_o <= line_for_addr(line_addr);
                        phase = PH_IDLE;
                    end else begin
                        count = count - 1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== bench/icache_tb.sv ====
/*
 * Instruction cache testbench
 * Fetch stimulus, reference tag/valid model and protocol assertions
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int RANDOM_FETCHES = 60;
    localparam int REFETCHES = 8;

    logic                                  clk;
    logic                                  reset;
    logic                                  flush;
    logic                                  fe_valid;
    logic [icache_pkg::PC_WIDTH-1:0]       fe_pc;
    logic                                  dec_ready;
    wire                                   ic_ready;
    wire                                   ic_valid;
    wire  [icache_pkg::PC_WIDTH-1:0]       ic_pc;
    wire  [icache_pkg::INST_WIDTH-1:0]     ic_inst;
    wire                                   mem_req;
    wire  [icache_pkg::LINE_ADDR_BITS-1:0] mem_addr;
    wire                                   mem_ready;
    wire                                   mem_valid;
    wire  [icache_pkg::LINE_WIDTH-1:0]     mem_data;

    integer seed;
    integer ready_seed = 93;
    int     errors;

    // ########################################
    // Reference model
    // ########################################

    logic [icache_pkg::NUM_LINES-1:0] model_valid;
    logic [icache_pkg::TAG_BITS-1:0]  model_tag [icache_pkg::NUM_LINES];
    logic [icache_pkg::PC_WIDTH-1:0]  held_pc;
    logic                             held_hit;
    logic                             busy;
    logic                             flush_pending;
    int                               accepted;
    int                               delivered;
    logic [icache_pkg::PC_WIDTH-1:0]  fetched_pcs [$];

    logic                              accept;
    logic                              xfer;
    logic                              pred_hit;
    logic [icache_pkg::INDEX_BITS-1:0] fe_idx;
    logic [icache_pkg::INDEX_BITS-1:0] held_idx;
    logic [icache_pkg::INST_WIDTH-1:0] exp_inst;

    // Upper half the PC, lower half its inverse
    function automatic logic [icache_pkg::INST_WIDTH-1:0] expected_inst(
        input logic [icache_pkg::PC_WIDTH-1:0] pc);
        return {pc, ~pc};
    endfunction

    assign accept   = fe_valid && ic_ready;
    assign xfer     = ic_valid && dec_ready;
    assign fe_idx   = fe_pc[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS];
    assign held_idx = held_pc[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS];
    assign pred_hit = model_valid[fe_idx]
                   && (model_tag[fe_idx] == fe_pc[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS]);
    assign exp_inst = expected_inst(held_pc);

    always @(posedge clk) begin
        if (reset) begin
            model_valid <= '0;
            busy <= 1'b0;
            flush_pending <= 1'b0;
            accepted <= 0;
            delivered <= 0;
        end else begin
            if (accept) begin
                held_pc <= fe_pc;
                held_hit <= pred_hit;
                accepted <= accepted + 1;
            end
            if (xfer) begin
                delivered <= delivered + 1;
            end
            busy <= accept || (busy && !xfer);
            // Refill fills the line of the held request
            if (mem_valid) begin
                model_valid[held_idx] <= 1'b1;
                model_tag[held_idx] <= held_pc[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS];
            end
            if (flush) begin
                flush_pending <= 1'b1;
            end
            // Flush lands when idle or as a word leaves
            if (flush_pending && (!busy || xfer)) begin
                model_valid <= '0;
                flush_pending <= 1'b0;
            end
        end
    end

    // ########################################
    // DUT and environment
    // ########################################

    tb_clock u_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    icache_mem_model u_mem (
        .clk_i       (clk),
        .reset_i     (reset),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_ready_o (mem_ready),
        .mem_valid_o (mem_valid),
        .mem_data_o  (mem_data)
    );

    icache_top uut (
        .clk_i       (clk),
        .reset_i     (reset),
        .flush_i     (flush),
        .fe_valid_i  (fe_valid),
        .fe_pc_i     (fe_pc),
        .ic_ready_o  (ic_ready),
        .ic_valid_o  (ic_valid),
        .ic_pc_o     (ic_pc),
        .ic_inst_o   (ic_inst),
        .dec_ready_i (dec_ready),
        .mem_req_o   (mem_req),
        .mem_addr_o  (mem_addr),
        .mem_ready_i (mem_ready),
        .mem_valid_i (mem_valid),
        .mem_data_i  (mem_data)
    );

    // ########################################
    // Checks
    // ########################################

    task automatic fail_run(input string reason);
        errors++;
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    a_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!ic_valid && !mem_req && ic_ready))
        else fail_run($sformatf("Mismatch at %0t: cache not idle after reset", $time));

    a_miss_request: assert property (@(posedge clk) disable iff (reset)
        (accept && !pred_hit) |=> (mem_req
            && (mem_addr == held_pc[icache_pkg::PC_WIDTH-1:icache_pkg::OFFSET_BITS])))
        else fail_run($sformatf("Mismatch at %0t: no line request for a miss", $time));

    a_hit_offer: assert property (@(posedge clk) disable iff (reset)
        (accept && pred_hit) |=> ic_valid)
        else fail_run($sformatf("Mismatch at %0t: hit not offered next cycle", $time));

    a_hit_no_mem: assert property (@(posedge clk) disable iff (reset)
        (busy && held_hit) |-> !mem_req)
        else fail_run($sformatf("Mismatch at %0t: memory request on a hit", $time));

    a_word: assert property (@(posedge clk) disable iff (reset)
        xfer |-> ((ic_pc == held_pc) && (ic_inst == exp_inst)))
        else fail_run($sformatf("Mismatch at %0t: wrong word for pc %h", $time, held_pc));

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (ic_valid && !dec_ready) |=> (ic_valid && $stable(ic_pc) && $stable(ic_inst)))
        else fail_run($sformatf("Mismatch at %0t: offer changed under stall", $time));

    a_flush_blocks: assert property (@(posedge clk) disable iff (reset)
        (flush_pending && (!busy || xfer)) |-> !ic_ready)
        else fail_run($sformatf("Mismatch at %0t: request taken at a flush", $time));

    // ########################################
    // Stimulus
    // ########################################

    task automatic wait_cycle(input string what, inout int waited);
        @(negedge clk);
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timed out at %0t waiting for %s", $time, what));
        end
    endtask

    // Offer one PC and return once the cache has taken it
    task automatic fetch(input logic [icache_pkg::PC_WIDTH-1:0] pc);
        int target;
        int waited;
        target = accepted + 1;
        waited = 0;
        fe_valid = 1'b1;
        fe_pc = pc;
        fetched_pcs.push_back(pc);
        while (accepted < target) begin
            wait_cycle("a fetch to be accepted", waited);
        end
        fe_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (delivered < accepted) begin
            wait_cycle("the decoder to take every word", waited);
        end
    endtask

    task automatic pulse_flush();
        int waited;
        waited = 0;
        flush = 1'b1;
        wait_cycle("the flush pulse", waited);
        flush = 1'b0;
    endtask

    // Decoder stalls about one cycle in four
    always @(negedge clk) begin
        dec_ready <= ($random(ready_seed) % 4) != 0;
    end

    initial begin
        int                              waited;
        int                              i;
        int                              last;
        logic [icache_pkg::PC_WIDTH-1:0] pc;
        seed = 93;
        errors = 0;
        flush = 1'b0;
        fe_valid = 1'b0;
        fe_pc = '0;
        dec_ready = 1'b0;
        waited = 0;
        while (reset !== 1'b0) begin
            wait_cycle("reset release", waited);
        end

        // Both words of one line, then a same-index conflict
        fetch(16'h0100);
        fetch(16'h0101);
        fetch(16'h0100);
        fetch(16'h0120);
        fetch(16'h0100);
        drain();

        // Four tags over all lines
        for (i = 0; i < RANDOM_FETCHES; i++) begin
            pc = 16'h0400 | ($random(seed) & 16'h007f);
            fetch(pc);
        end
        drain();

        // Cached lines must miss after a flush
        pulse_flush();
        last = fetched_pcs.size() - 1;
        for (i = 0; i < REFETCHES; i++) begin
            fetch(fetched_pcs[last - i]);
        end

        // Flush while a request is still held
        fetch(16'h0100);
        pulse_flush();
        fetch(16'h0100);
        fetch(16'h0101);
        drain();

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("Errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/icache_pkg.sv
design/icache_lookup.sv
design/icache_ctrl.sv
design/icache_data_array.sv
design/icache_top.sv
bench/tb_clock.sv
bench/icache_mem_model.sv
bench/icache_tb.sv
